/* common/router_consts.svh */
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// router directions, E W N S
`define NUM_PORTS 4

// one flit, routing field in the top bits
`define FLIT_WIDTH 16
`define DEST_WIDTH 2

// input buffer depth is 2**FIFO_ADDR_BITS
`define FIFO_ADDR_BITS 2

// free slots left when almostFull goes high
`define ALMOST_FULL_MARGIN 1

`endif

/* common/routerPkg.sv */
`include "router_consts.svh"

package routerPkg;

	// direction of a port, also used as flit destination
	typedef enum logic [`DEST_WIDTH-1:0] {
		EAST  = 2'd0,
		WEST  = 2'd1,
		NORTH = 2'd2,
		SOUTH = 2'd3
	} portId_t;

	// dest sits in the top bits, payload below
	typedef struct packed {
		portId_t dest;
		logic [`FLIT_WIDTH-`DEST_WIDTH-1:0] payload;
	} flit_t;

	// one bit per port, indexed by portId_t
	typedef logic [`NUM_PORTS-1:0] portMask_t;

endpackage

/* router/inputFifo.sv */
`include "router_consts.svh"

module inputFifo import routerPkg::*; #(
	parameter int ADDR_BITS = `FIFO_ADDR_BITS
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  write,
	input  flit_t writeFlit,
	input  logic  pop,
	output flit_t headFlit,
	output logic  empty,
	output logic  full,
	output logic  almostFull
);

	localparam int DEPTH = 2 ** ADDR_BITS;
	localparam logic [ADDR_BITS:0] FULL_LEVEL = (ADDR_BITS + 1)'(DEPTH);
	localparam logic [ADDR_BITS:0] AF_LEVEL = (ADDR_BITS + 1)'(DEPTH - `ALMOST_FULL_MARGIN);

	flit_t mem [DEPTH];

	logic [ADDR_BITS-1:0] rdPtr;
	logic [ADDR_BITS-1:0] wrPtr;
	logic [ADDR_BITS:0] count; // one extra bit so full is distinct from empty

	logic doWrite;
	logic doPop;

	// a write into a full buffer is dropped by the buffer itself
	assign doWrite = write && !full;
	assign doPop = pop && !empty;

	// entry storage
	always_ff @(posedge clk) begin
		if (doWrite) begin
			mem[wrPtr] <= writeFlit;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wrPtr <= '0;
		end else if (doWrite) begin
			wrPtr <= wrPtr + 1'b1; // wraps with the depth
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rdPtr <= '0;
		end else if (doPop) begin
			rdPtr <= rdPtr + 1'b1;
		end
	end

	// pop and write together leave the occupancy unchanged
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({doWrite, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// oldest entry always on the output
	assign headFlit = mem[rdPtr];

	assign empty = (count == '0);
	assign full = (count == FULL_LEVEL);
	assign almostFull = (count >= AF_LEVEL);

endmodule

/* router/switchAllocator.sv */
`include "router_consts.svh"

module switchAllocator import routerPkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  flit_t   [`NUM_PORTS-1:0]   headFlit,
	input  portMask_t                  empty,
	input  portMask_t                  stalled,
	output portMask_t                  pop,
	output portMask_t                  outGrant,
	output portId_t [`NUM_PORTS-1:0]   outSel
);

	// rotating priority, first input visited this cycle
	logic [`DEST_WIDTH-1:0] token;

	// per input, one-hot output it wants, zero when the buffer is empty
	portMask_t req [`NUM_PORTS];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			token <= '0;
		end else begin
			token <= token + 1'b1; // moves every clock, whether granted or not
		end
	end

	always_comb begin
		for (int i = 0; i < `NUM_PORTS; i++) begin
			if (empty[i]) begin
				req[i] = '0;
			end else begin
				req[i] = portMask_t'(1 << headFlit[i].dest);
			end
		end
	end

	// visit inputs from the token onward, first come first served per output
	always_comb begin
		portMask_t claimed;
		logic [`DEST_WIDTH-1:0] src;
		portId_t dst;

		claimed = stalled; // a stalled output looks already taken
		pop = '0;
		outGrant = '0;
		src = token;
		dst = EAST;
		for (int o = 0; o < `NUM_PORTS; o++) begin
			outSel[o] = EAST;
		end

		for (int k = 0; k < `NUM_PORTS; k++) begin
			src = token + `DEST_WIDTH'(k);
			dst = headFlit[src].dest;
			if ((req[src] & ~claimed) != '0) begin
				claimed[dst] = 1'b1;
				pop[src] = 1'b1;
				outGrant[dst] = 1'b1;
				outSel[dst] = portId_t'(src);
			end
		end
	end

endmodule

/* router/outputPort.sv */
`include "router_consts.svh"

module outputPort import routerPkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  flit_t [`NUM_PORTS-1:0]   heads,
	input  logic                     grant,
	input  portId_t                  sel,
	input  logic                     nextFull,
	input  logic                     nextAlmostFull,
	output flit_t                    dataOut,
	output logic                     opWrite,
	output logic                     stalled
);

	flit_t muxFlit;

	// crossbar leg for this direction
	assign muxFlit = heads[sel];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			dataOut <= '0;
		end else if (grant) begin
			dataOut <= muxFlit; // holds last flit between writes
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			opWrite <= 1'b0;
		end else begin
			opWrite <= grant;
		end
	end

	// downstream full, or almost full with a write already going out
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stalled <= 1'b0;
		end else begin
			stalled <= nextFull || (nextAlmostFull && opWrite);
		end
	end

endmodule

/* router/nocRouter.sv */
`include "router_consts.svh"

module nocRouter import routerPkg::*; (
	input  logic  clk,
	input  logic  reset,

	input  logic  writeE,
	input  flit_t dataInE,
	output logic  fullE,
	output logic  almostFullE,
	input  logic  nextFullE,
	input  logic  nextAlmostFullE,
	output flit_t dataOutE,
	output logic  opWriteE,

	input  logic  writeW,
	input  flit_t dataInW,
	output logic  fullW,
	output logic  almostFullW,
	input  logic  nextFullW,
	input  logic  nextAlmostFullW,
	output flit_t dataOutW,
	output logic  opWriteW,

	input  logic  writeN,
	input  flit_t dataInN,
	output logic  fullN,
	output logic  almostFullN,
	input  logic  nextFullN,
	input  logic  nextAlmostFullN,
	output flit_t dataOutN,
	output logic  opWriteN,

	input  logic  writeS,
	input  flit_t dataInS,
	output logic  fullS,
	output logic  almostFullS,
	input  logic  nextFullS,
	input  logic  nextAlmostFullS,
	output flit_t dataOutS,
	output logic  opWriteS
);

	flit_t [`NUM_PORTS-1:0] heads; // head flit of each input buffer
	portMask_t empty;
	portMask_t pop;
	portMask_t outGrant;
	portMask_t stalled;
	portId_t [`NUM_PORTS-1:0] outSel;

	// input buffers
	inputFifo fifoE (
		.clk(clk), .reset(reset),
		.write(writeE), .writeFlit(dataInE), .pop(pop[EAST]),
		.headFlit(heads[EAST]), .empty(empty[EAST]),
		.full(fullE), .almostFull(almostFullE)
	);

	inputFifo fifoW (
		.clk(clk), .reset(reset),
		.write(writeW), .writeFlit(dataInW), .pop(pop[WEST]),
		.headFlit(heads[WEST]), .empty(empty[WEST]),
		.full(fullW), .almostFull(almostFullW)
	);

	inputFifo fifoN (
		.clk(clk), .reset(reset),
		.write(writeN), .writeFlit(dataInN), .pop(pop[NORTH]),
		.headFlit(heads[NORTH]), .empty(empty[NORTH]),
		.full(fullN), .almostFull(almostFullN)
	);

	inputFifo fifoS (
		.clk(clk), .reset(reset),
		.write(writeS), .writeFlit(dataInS), .pop(pop[SOUTH]),
		.headFlit(heads[SOUTH]), .empty(empty[SOUTH]),
		.full(fullS), .almostFull(almostFullS)
	);

	switchAllocator alloc (
		.clk(clk),
		.reset(reset),
		.headFlit(heads),
		.empty(empty),
		.stalled(stalled),
		.pop(pop),
		.outGrant(outGrant),
		.outSel(outSel)
	);

	// output stage, one per direction
	outputPort outE (
		.clk(clk), .reset(reset),
		.heads(heads), .grant(outGrant[EAST]), .sel(outSel[EAST]),
		.nextFull(nextFullE), .nextAlmostFull(nextAlmostFullE),
		.dataOut(dataOutE), .opWrite(opWriteE), .stalled(stalled[EAST])
	);

	outputPort outW (
		.clk(clk), .reset(reset),
		.heads(heads), .grant(outGrant[WEST]), .sel(outSel[WEST]),
		.nextFull(nextFullW), .nextAlmostFull(nextAlmostFullW),
		.dataOut(dataOutW), .opWrite(opWriteW), .stalled(stalled[WEST])
	);

	outputPort outN (
		.clk(clk), .reset(reset),
		.heads(heads), .grant(outGrant[NORTH]), .sel(outSel[NORTH]),
		.nextFull(nextFullN), .nextAlmostFull(nextAlmostFullN),
		.dataOut(dataOutN), .opWrite(opWriteN), .stalled(stalled[NORTH])
	);

	outputPort outS (
		.clk(clk), .reset(reset),
		.heads(heads), .grant(outGrant[SOUTH]), .sel(outSel[SOUTH]),
		.nextFull(nextFullS), .nextAlmostFull(nextAlmostFullS),
		.dataOut(dataOutS), .opWrite(opWriteS), .stalled(stalled[SOUTH])
	);

endmodule

/* tb/routerChecks.sv */
`include "router_consts.svh"

module routerChecks import routerPkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  portMask_t              write,
	input  flit_t [`NUM_PORTS-1:0] dataIn,
	input  portMask_t              full,
	input  portMask_t              almostFull,
	input  portMask_t              nextFull,
	input  portMask_t              nextAlmostFull,
	input  portMask_t              opWrite,
	input  flit_t [`NUM_PORTS-1:0] dataOut,
	input  logic                   fairCheck,
	output int                     valueErrors,
	output int                     protocolErrors,
	output int                     pending
);

	localparam int PAYLOAD_W = `FLIT_WIDTH - `DEST_WIDTH;

	flit_t expQ [`NUM_PORTS][`NUM_PORTS][$]; // [source][destination]
	portId_t northHist [$]; // sources of recent north writes

	function automatic string dirName(input int d);
		case (d)
			0: return "E";
			1: return "W";
			2: return "N";
			default: return "S";
		endcase
	endfunction

	// tb puts the sending input in the top payload bits
	function automatic portId_t sourceOf(input flit_t f);
		return portId_t'(f.payload[PAYLOAD_W-1 -: `DEST_WIDTH]);
	endfunction

	initial begin
		valueErrors = 0;
		protocolErrors = 0;
		pending = 0;
	end

	always @(posedge clk) begin
		flit_t got;
		flit_t want;
		portId_t src;
		portMask_t seen;
		int total;

		if (reset) begin
			for (int i = 0; i < `NUM_PORTS; i++) begin
				for (int o = 0; o < `NUM_PORTS; o++) begin
					expQ[i][o].delete();
				end
			end
		end else begin
			for (int i = 0; i < `NUM_PORTS; i++) begin
				if (write[i]) begin
					expQ[i][dataIn[i].dest].push_back(dataIn[i]);
				end
			end
			for (int o = 0; o < `NUM_PORTS; o++) begin
				if (opWrite[o]) begin
					got = dataOut[o];
					src = sourceOf(got);
					assert (got.dest == portId_t'(o)) else begin
						valueErrors++;
						$display("ERROR %0t dataOut%s.dest expected %s got %s", $time,
							dirName(o), dirName(o), dirName(got.dest));
					end
					assert (expQ[src][o].size() != 0) else begin
						protocolErrors++;
						$display("%0t: output %s sent a flit that input %s never wrote for it",
							$time, dirName(o), dirName(src));
					end
					if (expQ[src][o].size() != 0) begin
						want = expQ[src][o].pop_front();
						assert (got == want) else begin
							valueErrors++;
							$display("ERROR %0t dataOut%s expected %h got %h", $time,
								dirName(o), want, got);
						end
					end
				end
			end
		end

		// round-robin window on north
		if (!fairCheck) begin
			northHist.delete();
		end else if (opWrite[NORTH]) begin
			northHist.push_back(sourceOf(dataOut[NORTH]));
			if (northHist.size() > `NUM_PORTS) begin
				void'(northHist.pop_front());
			end
			if (northHist.size() == `NUM_PORTS) begin
				seen = '0;
				for (int j = 0; j < `NUM_PORTS; j++) begin
					seen[northHist[j]] = 1'b1;
				end
				assert (seen == '1) else begin
					valueErrors++;
					$display("ERROR %0t dataOutN source mask expected %b got %b", $time,
						portMask_t'('1), seen);
				end
			end
		end

		total = 0;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			for (int o = 0; o < `NUM_PORTS; o++) begin
				total += expQ[i][o].size();
			end
		end
		pending <= total;
	end

	resetQuiet: assert property (@(posedge clk)
		(reset || $past(reset)) |-> (opWrite == '0 && full == '0 && almostFull == '0))
		else begin
			valueErrors++;
			$display("ERROR %0t opWrite full almostFull expected 0 0 0 got %b %b %b", $time,
				$sampled(opWrite), $sampled(full), $sampled(almostFull));
		end

	for (genvar p = 0; p < `NUM_PORTS; p++) begin : perPort
		// stall register sits between the level and the allocator
		fullStops: assert property (@(posedge clk) disable iff (reset)
			nextFull[p] |-> ##2 !opWrite[p])
			else begin
				valueErrors++;
				$display("ERROR %0t opWrite%s expected 0 got 1", $time, dirName(p));
			end

		almostFullStops: assert property (@(posedge clk) disable iff (reset)
			(nextAlmostFull[p] && opWrite[p]) |-> ##2 !opWrite[p])
			else begin
				valueErrors++;
				$display("ERROR %0t opWrite%s expected 0 got 1", $time, dirName(p));
			end
	end

endmodule

/* tb/routerTb.sv */
`include "router_consts.svh"

module routerTb
	import routerPkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int SEED = 89775;
	localparam int DEPTH = 2 ** `FIFO_ADDR_BITS;
	localparam int PAYLOAD_W = `FLIT_WIDTH - `DEST_WIDTH;
	localparam int CONT_CYCLES = 60;
	localparam int RAND_CYCLES = 400;
	localparam int DRAIN_LIMIT = 300;
	// upper bound on flits written by all tests
	localparam int STIM_FLITS = `NUM_PORTS + DEPTH + `NUM_PORTS * (CONT_CYCLES + RAND_CYCLES);
	localparam int WATCHDOG_CYCLES = 50 * STIM_FLITS + 500;

	logic clk;
	logic reset;
	portMask_t write;
	flit_t [`NUM_PORTS-1:0] dataIn;
	portMask_t nextFull;
	portMask_t nextAlmostFull;
	logic fairCheck;
	wire portMask_t full;
	wire portMask_t almostFull;
	wire portMask_t opWrite;
	wire flit_t [`NUM_PORTS-1:0] dataOut;

	int valueErrors;
	int protocolErrors;
	int pending;
	int tbErrors;

	nocRouter DUT (
		.clk(clk), .reset(reset),
		.writeE(write[EAST]), .dataInE(dataIn[EAST]),
		.fullE(full[EAST]), .almostFullE(almostFull[EAST]),
		.nextFullE(nextFull[EAST]), .nextAlmostFullE(nextAlmostFull[EAST]),
		.dataOutE(dataOut[EAST]), .opWriteE(opWrite[EAST]),
		.writeW(write[WEST]), .dataInW(dataIn[WEST]),
		.fullW(full[WEST]), .almostFullW(almostFull[WEST]),
		.nextFullW(nextFull[WEST]), .nextAlmostFullW(nextAlmostFull[WEST]),
		.dataOutW(dataOut[WEST]), .opWriteW(opWrite[WEST]),
		.writeN(write[NORTH]), .dataInN(dataIn[NORTH]),
		.fullN(full[NORTH]), .almostFullN(almostFull[NORTH]),
		.nextFullN(nextFull[NORTH]), .nextAlmostFullN(nextAlmostFull[NORTH]),
		.dataOutN(dataOut[NORTH]), .opWriteN(opWrite[NORTH]),
		.writeS(write[SOUTH]), .dataInS(dataIn[SOUTH]),
		.fullS(full[SOUTH]), .almostFullS(almostFull[SOUTH]),
		.nextFullS(nextFull[SOUTH]), .nextAlmostFullS(nextAlmostFull[SOUTH]),
		.dataOutS(dataOut[SOUTH]), .opWriteS(opWrite[SOUTH])
	);

	routerChecks checks (
		.clk(clk), .reset(reset),
		.write(write), .dataIn(dataIn),
		.full(full), .almostFull(almostFull),
		.nextFull(nextFull), .nextAlmostFull(nextAlmostFull),
		.opWrite(opWrite), .dataOut(dataOut),
		.fairCheck(fairCheck),
		.valueErrors(valueErrors), .protocolErrors(protocolErrors), .pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("watchdog expired, the tests did not finish in time");
		$display("errors: value %0d protocol %0d testbench %0d", valueErrors, protocolErrors,
			tbErrors);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic flit_t makeFlit(input portId_t src, input portId_t dst);
		flit_t f;
		f.dest = dst;
		f.payload = PAYLOAD_W'($urandom);
		f.payload[PAYLOAD_W-1 -: `DEST_WIDTH] = src; // source tag
		return f;
	endfunction

	// writes only while almostFull is low, so the buffer can never overflow
	task automatic offerFlit(input portId_t src, input portId_t dst);
		if (almostFull[src]) begin
			write[src] <= 1'b0;
		end else begin
			write[src] <= 1'b1;
			dataIn[src] <= makeFlit(src, dst);
		end
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		repeat (2) @(posedge clk);
		while (pending != 0 && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		repeat (2) @(posedge clk);
	endtask

	// stored at one edge, popped at the next, opWrite right after
	task automatic checkLatency(input portId_t src, input portId_t dst);
		@(posedge clk);
		write[src] <= 1'b1;
		dataIn[src] <= makeFlit(src, dst);
		@(posedge clk);
		write[src] <= 1'b0;
		@(posedge clk);
		assert (!opWrite[dst]) else begin
			tbErrors++;
			$display("ERROR %0t opWrite[%0d] expected 0 got 1", $time, dst);
		end
		@(posedge clk);
		assert (opWrite[dst]) else begin
			tbErrors++;
			$display("ERROR %0t opWrite[%0d] expected 1 got 0", $time, dst);
		end
	endtask

	task automatic checkLevels(input portId_t src);
		logic expAf;
		logic expFull;
		nextFull <= '1; // nothing leaves while this runs
		repeat (2) @(posedge clk);
		for (int i = 1; i <= DEPTH; i++) begin
			@(posedge clk);
			write[src] <= 1'b1;
			dataIn[src] <= makeFlit(src, portId_t'($urandom_range(3)));
			@(posedge clk);
			write[src] <= 1'b0;
			@(posedge clk);
			expAf = (i >= DEPTH - `ALMOST_FULL_MARGIN);
			expFull = (i >= DEPTH);
			assert (almostFull[src] == expAf) else begin
				tbErrors++;
				$display("ERROR %0t almostFull[%0d] expected %b got %b", $time, src, expAf,
					almostFull[src]);
			end
			assert (full[src] == expFull) else begin
				tbErrors++;
				$display("ERROR %0t full[%0d] expected %b got %b", $time, src, expFull,
					full[src]);
			end
		end
		nextFull <= '0;
	endtask

	task automatic runContention();
		fairCheck <= 1'b1;
		repeat (CONT_CYCLES) begin
			@(posedge clk);
			for (int i = 0; i < `NUM_PORTS; i++) begin
				offerFlit(portId_t'(i), NORTH);
			end
		end
		@(posedge clk);
		write <= '0;
		fairCheck <= 1'b0; // buffers drain unevenly from here
	endtask

	task automatic runRandom();
		repeat (RAND_CYCLES) begin
			@(posedge clk);
			for (int i = 0; i < `NUM_PORTS; i++) begin
				if ($urandom_range(99) < 40) begin
					offerFlit(portId_t'(i), portId_t'($urandom_range(3)));
				end else begin
					write[i] <= 1'b0;
				end
				nextFull[i] <= ($urandom_range(99) < 15);
				nextAlmostFull[i] <= ($urandom_range(99) < 25);
			end
		end
		@(posedge clk);
		write <= '0;
		nextFull <= '0;
		nextAlmostFull <= '0;
	endtask

	initial begin
		int totalErrors;
		void'($urandom(SEED));
		tbErrors = 0;
		reset = 1'b1;
		write = '0;
		dataIn = '0;
		nextFull = '0;
		nextAlmostFull = '0;
		fairCheck = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		for (int d = 0; d < `NUM_PORTS; d++) begin
			checkLatency(portId_t'(d), portId_t'((d + 1) % `NUM_PORTS));
		end
		checkLevels(WEST);
		waitDrained();
		runContention();
		waitDrained();
		runRandom();
		waitDrained();

		assert (pending == 0) else begin
			tbErrors++;
			$display("%0d flits were written but never came out", pending);
		end
		totalErrors = valueErrors + protocolErrors + tbErrors;
		$display("errors: value %0d protocol %0d testbench %0d", valueErrors, protocolErrors,
			tbErrors);
		if (totalErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+common
common/routerPkg.sv
router/inputFifo.sv
router/switchAllocator.sv
router/outputPort.sv
router/nocRouter.sv
tb/routerChecks.sv
tb/routerTb.sv
